//--- build.f
+incdir+tb
source/cpuPkg.sv
source/ctrlIf.sv
source/controlDecoder.sv
source/registerFile.sv
source/aluExecute.sv
source/resultWriteback.sv
source/cpuCore.sv
tb/cpuCoreTb.sv

//--- tb/cpuModel.svh
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

logic [31:0] modelRegs [32];   // Architectural registers as the model sees them
logic [31:0] modelPc;

function automatic void resetModel(input logic [31:0] startPc);
    for (int i = 0; i < 32; i++) begin
        modelRegs[i] = '0;
    end
    modelPc = startPc;
endfunction

// Logical shift plus a fill of sign bits from the top
function automatic logic [31:0] shiftRightArith(input logic [31:0] value,
                                                input logic [4:0]  amount);
    logic [31:0] fill;
    fill = value[31] ? ~(32'hffff_ffff >> amount) : 32'd0;
    return (value >> amount) | fill;
endfunction

function automatic logic lessSigned(input logic [31:0] a, input logic [31:0] b);
    if (a[31] != b[31]) begin
        return a[31];   // Differing signs, negative one is smaller
    end
    return a < b;
endfunction

function automatic void expectedStep(
    input  logic [31:0] word,
    output logic        expValid,
    output logic [4:0]  expReg,
    output logic [31:0] expData,
    output logic [31:0] expPc
);
    instrWord_t  w;
    logic [31:0] rsVal;
    logic [31:0] rtVal;
    logic [31:0] sImm;
    logic [31:0] zImm;
    logic [31:0] pc4;
    logic        taken;
    logic        doWrite;

    w       = word;
    rsVal   = modelRegs[w.rType.rs];
    rtVal   = modelRegs[w.rType.rt];
    sImm    = {{16{w.iType.imm[15]}}, w.iType.imm};
    zImm    = {16'd0, w.iType.imm};
    pc4     = modelPc + 32'd4;
    taken   = 1'b0;
    doWrite = 1'b0;
    expReg  = 5'd0;
    expData = 32'd0;
    expPc   = pc4;

    case (w.rType.op)
        OP_SPECIAL: begin
            doWrite = 1'b1;
            expReg  = w.rType.rd;
            case (w.rType.funct)
                FN_ADDU: expData = rsVal + rtVal;
                FN_SUBU: expData = rsVal - rtVal;
                FN_AND:  expData = rsVal & rtVal;
                FN_OR:   expData = rsVal | rtVal;
                FN_XOR:  expData = rsVal ^ rtVal;
                FN_SLT:  expData = {31'd0, lessSigned(rsVal, rtVal)};
                FN_SLTU: expData = {31'd0, rsVal < rtVal};
                FN_SLL:  expData = rtVal << w.rType.shamt;
                FN_SRL:  expData = rtVal >> w.rType.shamt;
                FN_SRA:  expData = shiftRightArith(rtVal, w.rType.shamt);
                FN_SLLV: expData = rtVal << rsVal[4:0];
                FN_SRLV: expData = rtVal >> rsVal[4:0];
                FN_SRAV: expData = shiftRightArith(rtVal, rsVal[4:0]);
                FN_JR: begin
                    doWrite = 1'b0;
                    expPc   = rsVal;
                end
                FN_JALR: begin
                    expData = modelPc + 32'd8;   // Link into rd
                    expPc   = rsVal;
                end
                default: doWrite = 1'b0;
            endcase
        end
        OP_REGIMM: begin
            if (w.iType.rt == RI_BLTZ) begin
                taken = ($signed(rsVal) < 0);
            end else if (w.iType.rt == RI_BGEZ) begin
                taken = ($signed(rsVal) >= 0);
            end
        end
        OP_J:    expPc = {pc4[31:28], w.jType.target, 2'b00};
        OP_JAL: begin
            expPc   = {pc4[31:28], w.jType.target, 2'b00};
            doWrite = 1'b1;
            expReg  = 5'd31;
            expData = modelPc + 32'd8;
        end
        OP_BEQ:   taken = (rsVal == rtVal);
        OP_BNE:   taken = (rsVal != rtVal);
        OP_BLEZ:  taken = ($signed(rsVal) <= 0);
        OP_BGTZ:  taken = ($signed(rsVal) > 0);
        OP_ADDIU: expData = rsVal + sImm;
        OP_SLTI:  expData = {31'd0, lessSigned(rsVal, sImm)};
        OP_SLTIU: expData = {31'd0, rsVal < sImm};   // Sign-extended, compared unsigned
        OP_ANDI:  expData = rsVal & zImm;
        OP_ORI:   expData = rsVal | zImm;
        OP_XORI:  expData = rsVal ^ zImm;
        OP_LUI:   expData = {w.iType.imm, 16'd0};
        default: ;
    endcase

    if (w.rType.op inside {OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI}) begin
        doWrite = 1'b1;
        expReg  = w.iType.rt;
    end
    if (taken) begin
        expPc = pc4 + (sImm << 2);
    end
    expValid = doWrite && (expReg != 5'd0);
endfunction

function automatic void commitStep(input logic        valid,
                                   input logic [4:0]  regNum,
                                   input logic [31:0] data,
                                   input logic [31:0] nextPc);
    if (valid) begin
        modelRegs[regNum] = data;
    end
    modelPc = nextPc;
endfunction

`endif

//--- tb/cpuCoreTb.sv
`timescale 1ns/10ps

module cpuCoreTb;
    import cpuPkg::*;

    localparam logic [31:0] START_PC = 32'h0000_0400;

    typedef struct {
        logic        valid;
        logic [4:0]  regNum;
        logic [31:0] data;
        logic [31:0] nextPc;
    } expect_t;

    logic        clk;
    logic        reset;
    logic        instrValid;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        wbValid;
    logic [4:0]  wbReg;
    logic [31:0] wbData;

    expect_t     expQ[$];   // One entry per driven cycle
    int unsigned issuedCount;
    int unsigned checkedCount;

    `include "cpuModel.svh"

    cpuCore #(
        .RESET_PC (START_PC)
    ) i_dut (
        .clk        (clk),
        .reset      (reset),
        .instrValid (instrValid),
        .instr      (instr),
        .pc         (pc),
        .wbValid    (wbValid),
        .wbReg      (wbReg),
        .wbData     (wbData)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

    task automatic failRun();
        $display("Result: FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic checkWb(input logic expValid, input logic [4:0] expReg,
                           input logic [31:0] expData);
        if (wbValid !== expValid) begin
            $display("error wbValid: got %h, expected %h (pc %h)", wbValid, expValid, pc);
            failRun();
        end
        if (expValid && (wbReg !== expReg)) begin
            $display("error wbReg: got %h, expected %h", wbReg, expReg);
            failRun();
        end
        if (expValid && (wbData !== expData)) begin
            $display("error wbData: got %h, expected %h (wbReg %h)", wbData, expData, wbReg);
            failRun();
        end
    endtask

    task automatic checkPc(input logic [31:0] expPc);
        if (pc !== expPc) begin
            $display("error pc: got %h, expected %h", pc, expPc);
            failRun();
        end
    endtask

    function automatic logic [31:0] encodeR(input logic [5:0] fn, input logic [4:0] rs,
                                            input logic [4:0] rt, input logic [4:0] rd,
                                            input logic [4:0] sh);
        instrWord_t w;
        w.rType.op    = OP_SPECIAL;
        w.rType.rs    = rs;
        w.rType.rt    = rt;
        w.rType.rd    = rd;
        w.rType.shamt = sh;
        w.rType.funct = funct_e'(fn);
        return w;
    endfunction

    function automatic logic [31:0] encodeI(input logic [5:0] op, input logic [4:0] rs,
                                            input logic [4:0] rt, input logic [15:0] imm);
        instrWord_t w;
        w.iType.op  = opcode_e'(op);
        w.iType.rs  = rs;
        w.iType.rt  = rt;
        w.iType.imm = imm;
        return w;
    endfunction

    function automatic logic [31:0] encodeJ(input logic [5:0] op, input logic [25:0] target);
        instrWord_t w;
        w.jType.op     = opcode_e'(op);
        w.jType.target = target;
        return w;
    endfunction

    // Small register range keeps operands reused across instructions
    function automatic logic [31:0] randomAluInstr();
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  sh;
        logic [15:0] imm;
        rs  = 5'($urandom_range(0, 7));
        rt  = 5'($urandom_range(0, 7));
        rd  = 5'($urandom_range(0, 7));
        sh  = 5'($urandom);
        imm = 16'($urandom);
        case ($urandom_range(0, 19))
            0:  return encodeR(FN_ADDU, rs, rt, rd, 5'd0);
            1:  return encodeR(FN_SUBU, rs, rt, rd, 5'd0);
            2:  return encodeR(FN_AND, rs, rt, rd, 5'd0);
            3:  return encodeR(FN_OR, rs, rt, rd, 5'd0);
            4:  return encodeR(FN_XOR, rs, rt, rd, 5'd0);
            5:  return encodeR(FN_SLT, rs, rt, rd, 5'd0);
            6:  return encodeR(FN_SLTU, rs, rt, rd, 5'd0);
            7:  return encodeR(FN_SLL, 5'd0, rt, rd, sh);
            8:  return encodeR(FN_SRL, 5'd0, rt, rd, sh);
            9:  return encodeR(FN_SRA, 5'd0, rt, rd, sh);
            10: return encodeR(FN_SLLV, rs, rt, rd, 5'd0);
            11: return encodeR(FN_SRLV, rs, rt, rd, 5'd0);
            12: return encodeR(FN_SRAV, rs, rt, rd, 5'd0);
            13: return encodeI(OP_ADDIU, rs, rt, imm);
            14: return encodeI(OP_ANDI, rs, rt, imm);
            15: return encodeI(OP_ORI, rs, rt, imm);
            16: return encodeI(OP_XORI, rs, rt, imm);
            17: return encodeI(OP_SLTI, rs, rt, imm);
            18: return encodeI(OP_SLTIU, rs, rt, imm);
            default: return encodeI(OP_LUI, 5'd0, rt, imm);
        endcase
    endfunction

    // Drive one cycle and queue what the model expects from it
    task automatic issue(input logic valid, input logic [31:0] word);
        expect_t e;
        @(negedge clk);
        instrValid = valid;
        instr      = word;
        if (valid) begin
            expectedStep(word, e.valid, e.regNum, e.data, e.nextPc);
        end else begin
            e.valid  = 1'b0;
            e.regNum = 5'd0;
            e.data   = 32'd0;
            e.nextPc = modelPc;   // Gap holds pc
        end
        commitStep(e.valid, e.regNum, e.data, e.nextPc);
        expQ.push_back(e);
        issuedCount++;
    endtask

    // Entry taken at the completing edge, outputs compared half a cycle later
    initial begin
        expect_t e;
        forever begin
            @(posedge clk);
            if (!reset && (expQ.size() > 0)) begin
                e = expQ.pop_front();
                @(negedge clk);
                checkWb(e.valid, e.regNum, e.data);
                checkPc(e.nextPc);
                checkedCount++;
            end
        end
    end

    initial begin
        int unsigned waited;
        void'($urandom(32'h22ac_93df));
        reset        = 1'b1;
        instrValid   = 1'b0;
        instr        = '0;
        issuedCount  = 0;
        checkedCount = 0;
        resetModel(START_PC);

        waited = 0;
        while (reset && (waited < 20)) begin
            @(posedge clk);
            waited++;
        end
        if (reset) begin
            $display("reset was never released");
            failRun();
        end

        repeat (4) issue(1'b0, 32'h0000_0000);   // Idle after reset

        // Register 0 ignores writes and reads as zero
        issue(1'b1, encodeI(OP_ADDIU, 5'd0, 5'd1, 16'h0007));
        issue(1'b1, encodeI(OP_ADDIU, 5'd1, 5'd0, 16'h1234));
        issue(1'b1, encodeR(FN_SLL, 5'd0, 5'd1, 5'd0, 5'd4));
        issue(1'b1, encodeR(FN_ADDU, 5'd0, 5'd0, 5'd1, 5'd0));
        issue(1'b1, encodeI(OP_ORI, 5'd0, 5'd2, 16'h0000));

        for (int i = 0; i < 300; i++) begin
            if ($urandom_range(0, 7) == 0) begin
                issue(1'b0, $urandom);   // Gap with junk on instr
            end else begin
                issue(1'b1, randomAluInstr());
            end
        end

        // Branch operands
        issue(1'b1, encodeI(OP_ADDIU, 5'd0, 5'd1, 16'd5));
        issue(1'b1, encodeI(OP_ADDIU, 5'd0, 5'd2, 16'd5));
        issue(1'b1, encodeI(OP_ADDIU, 5'd0, 5'd3, 16'hfffd));   // -3
        issue(1'b1, encodeI(OP_ADDIU, 5'd0, 5'd4, 16'd0));
        issue(1'b1, encodeI(OP_BEQ, 5'd1, 5'd2, 16'h0010));
        issue(1'b1, encodeI(OP_BEQ, 5'd1, 5'd3, 16'h0010));
        issue(1'b1, encodeI(OP_BNE, 5'd1, 5'd3, 16'hfff8));
        issue(1'b1, encodeI(OP_BNE, 5'd1, 5'd2, 16'hfff8));
        issue(1'b1, encodeI(OP_BLEZ, 5'd3, 5'd0, 16'h0020));
        issue(1'b1, encodeI(OP_BLEZ, 5'd4, 5'd0, 16'h0004));
        issue(1'b1, encodeI(OP_BLEZ, 5'd1, 5'd0, 16'h0004));
        issue(1'b1, encodeI(OP_BGTZ, 5'd1, 5'd0, 16'hffe0));
        issue(1'b1, encodeI(OP_BGTZ, 5'd4, 5'd0, 16'hffe0));
        issue(1'b1, encodeI(OP_BGTZ, 5'd3, 5'd0, 16'hffe0));
        issue(1'b1, encodeI(OP_REGIMM, 5'd3, RI_BLTZ, 16'h0040));
        issue(1'b1, encodeI(OP_REGIMM, 5'd4, RI_BLTZ, 16'h0040));
        issue(1'b1, encodeI(OP_REGIMM, 5'd4, RI_BGEZ, 16'hff00));
        issue(1'b1, encodeI(OP_REGIMM, 5'd3, RI_BGEZ, 16'hff00));

        // Jumps and links
        issue(1'b1, encodeJ(OP_J, 26'h000_0123));
        issue(1'b1, encodeJ(OP_JAL, 26'h000_0456));
        issue(1'b1, encodeI(OP_ORI, 5'd0, 5'd5, 16'h2000));
        issue(1'b1, encodeI(OP_ORI, 5'd0, 5'd6, 16'h3000));
        issue(1'b1, encodeR(FN_JR, 5'd5, 5'd0, 5'd0, 5'd0));
        issue(1'b1, encodeR(FN_JALR, 5'd6, 5'd0, 5'd7, 5'd0));
        issue(1'b1, encodeR(FN_JALR, 5'd5, 5'd0, 5'd0, 5'd0));
        issue(1'b1, encodeR(FN_ADDU, 5'd31, 5'd7, 5'd8, 5'd0));   // Reads both links

        // Gaps and undefined encodings
        issue(1'b0, encodeJ(OP_J, 26'h3ff_ffff));
        issue(1'b0, 32'h0000_0000);
        issue(1'b1, encodeI(6'h3f, 5'd1, 5'd9, 16'h5555));
        issue(1'b1, encodeR(6'h3f, 5'd1, 5'd2, 5'd9, 5'd0));
        issue(1'b1, encodeI(OP_REGIMM, 5'd3, 5'd9, 16'h0040));
        issue(1'b0, 32'h0000_0000);
        issue(1'b0, 32'h0000_0000);

        waited = 0;
        while ((checkedCount < issuedCount) && (waited < 20)) begin
            @(posedge clk);
            waited++;
        end
        if (checkedCount < issuedCount) begin
            $display("results still outstanding when the run ended");
            failRun();
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

//--- source/cpuCore.sv
`timescale 1ns/10ps

module cpuCore #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        instrValid,
    input  logic [31:0] instr,
    output logic [31:0] pc,
    output logic        wbValid,
    output logic [4:0]  wbReg,
    output logic [31:0] wbData
);

    logic        branchCond;
    logic [31:0] rsData;
    logic [31:0] rtData;
    logic [31:0] aluResult;
    logic        writeEnable;
    logic [4:0]  writeAddr;
    logic [31:0] writeData;

    ctrlIf ctrlBus ();

    controlDecoder uDecoder (
        .instr      (instr),
        .branchCond (branchCond),
        .ctrl       (ctrlBus.decoder)
    );

    registerFile uRegFile (
        .clk         (clk),
        .reset       (reset),
        .rsAddr      (instr[25:21]),
        .rtAddr      (instr[20:16]),
        .rsData      (rsData),
        .rtData      (rtData),
        .writeEnable (writeEnable),
        .writeAddr   (writeAddr),
        .writeData   (writeData)
    );

    aluExecute uExecute (
        .instr      (instr),
        .rsData     (rsData),
        .rtData     (rtData),
        .ctrl       (ctrlBus.execute),
        .aluResult  (aluResult),
        .branchCond (branchCond)
    );

    resultWriteback #(
        .RESET_PC (RESET_PC)
    ) uWriteback (
        .clk         (clk),
        .reset       (reset),
        .instrValid  (instrValid),
        .instr       (instr),
        .rsData      (rsData),
        .aluResult   (aluResult),
        .ctrl        (ctrlBus.result),
        .writeEnable (writeEnable),
        .writeAddr   (writeAddr),
        .writeData   (writeData),
        .pc          (pc),
        .wbValid     (wbValid),
        .wbReg       (wbReg),
        .wbData      (wbData)
    );

endmodule

//--- source/resultWriteback.sv
`timescale 1ns/10ps

module resultWriteback #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               instrValid,
    input  cpuPkg::instrWord_t instr,
    input  logic [31:0]        rsData,
    input  logic [31:0]        aluResult,
    ctrlIf.result              ctrl,
    output logic               writeEnable,
    output logic [4:0]         writeAddr,
    output logic [31:0]        writeData,
    output logic [31:0]        pc,
    output logic               wbValid,
    output logic [4:0]         wbReg,
    output logic [31:0]        wbData
);
    import cpuPkg::*;

    logic [31:0] pcPlus4;
    logic [31:0] pcPlus8;
    logic [31:0] branchOffset;
    logic [31:0] nextPc;

    assign pcPlus4      = pc + 32'd4;
    assign pcPlus8      = pc + 32'd8; // Link address, no delay slot
    assign branchOffset = {{14{instr.iType.imm[15]}}, instr.iType.imm, 2'b00};

    always_comb begin
        case (ctrl.pcSel)
            PC_BRANCH: nextPc = pcPlus4 + branchOffset;
            PC_JUMP:   nextPc = {pcPlus4[31:28], instr.jType.target, 2'b00};
            PC_REG:    nextPc = rsData;
            default:   nextPc = pcPlus4;
        endcase
    end

    always_comb begin
        case (ctrl.regDst)
            REG_DST_RD:   writeAddr = instr.rType.rd;
            REG_DST_LINK: writeAddr = 5'd31;
            default:      writeAddr = instr.rType.rt;
        endcase
    end

    assign writeEnable = instrValid && ctrl.regWrite && (writeAddr != 5'd0);
    assign writeData   = (ctrl.wbSel == WB_LINK) ? pcPlus8 : aluResult;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc      <= RESET_PC;
            wbValid <= 1'b0;
        end else begin
            if (instrValid) begin
                pc <= nextPc; // Holds through gaps
            end
            wbValid <= writeEnable;
        end
    end

    // Result payload, only meaningful while wbValid is high
    always_ff @(posedge clk) begin
        if (writeEnable) begin
            wbReg  <= writeAddr;
            wbData <= writeData;
        end
    end

endmodule

//--- source/aluExecute.sv
`timescale 1ns/10ps

module aluExecute (
    input  cpuPkg::instrWord_t instr,
    input  logic [31:0]        rsData,
    input  logic [31:0]        rtData,
    ctrlIf.execute             ctrl,
    output logic [31:0]        aluResult,
    output logic               branchCond
);
    import cpuPkg::*;

    logic        zeroExt;
    logic [31:0] immExt;
    logic [31:0] operandB;
    logic [4:0]  varShamt;

    // Logical immediates are zero-extended, everything else sign-extended
    assign zeroExt  = (instr.iType.op == OP_ANDI) || (instr.iType.op == OP_ORI) ||
                      (instr.iType.op == OP_XORI);
    assign immExt   = zeroExt ? {16'd0, instr.iType.imm}
                              : {{16{instr.iType.imm[15]}}, instr.iType.imm};
    assign operandB = ctrl.aluSrc ? immExt : rtData;
    assign varShamt = rsData[4:0];

    // Branch compares use rs against rt or against zero
    always_comb begin
        case (ctrl.aluOp)
            ALU_EQ:  branchCond = (rsData == rtData);
            ALU_NEQ: branchCond = (rsData != rtData);
            ALU_LES: branchCond = rsData[31];
            ALU_LEQ: branchCond = rsData[31] || (rsData == 32'd0);
            ALU_GRT: branchCond = !rsData[31] && (rsData != 32'd0);
            ALU_GEQ: branchCond = !rsData[31];
            default: branchCond = 1'b0;
        endcase
    end

    always_comb begin
        case (ctrl.aluOp)
            ALU_ADD:  aluResult = rsData + operandB;
            ALU_SUB:  aluResult = rsData - operandB;
            ALU_AND:  aluResult = rsData & operandB;
            ALU_OR:   aluResult = rsData | operandB;
            ALU_XOR:  aluResult = rsData ^ operandB;
            ALU_SLL:  aluResult = operandB << ctrl.shamt;
            ALU_SLLV: aluResult = operandB << varShamt;
            ALU_SRL:  aluResult = operandB >> ctrl.shamt;
            ALU_SRLV: aluResult = operandB >> varShamt;
            ALU_SRA:  aluResult = $signed(operandB) >>> ctrl.shamt;
            ALU_SRAV: aluResult = $signed(operandB) >>> varShamt;
            ALU_SLT:  aluResult = {31'd0, $signed(rsData) < $signed(operandB)};
            ALU_SLTU: aluResult = {31'd0, rsData < operandB};
            default:  aluResult = '0;
        endcase
    end

endmodule

//--- source/registerFile.sv
`timescale 1ns/10ps

module registerFile (
    input  logic        clk,
    input  logic        reset,
    input  logic [4:0]  rsAddr,
    input  logic [4:0]  rtAddr,
    output logic [31:0] rsData,
    output logic [31:0] rtData,
    input  logic        writeEnable,
    input  logic [4:0]  writeAddr,
    input  logic [31:0] writeData
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && (writeAddr != 5'd0)) begin
            regs[writeAddr] <= writeData; // Register 0 never written
        end
    end

    // Asynchronous reads, register 0 hardwired to zero
    assign rsData = (rsAddr == 5'd0) ? '0 : regs[rsAddr];
    assign rtData = (rtAddr == 5'd0) ? '0 : regs[rtAddr];

endmodule

//--- source/controlDecoder.sv
`timescale 1ns/10ps

module controlDecoder (
    input  cpuPkg::instrWord_t instr,
    input  logic               branchCond,
    ctrlIf.decoder             ctrl
);
    import cpuPkg::*;

    logic   isBranch;   // Conditional branch opcode
    pcSel_e jumpSel;    // Next-PC choice when no branch is taken

    always_comb begin
        ctrl.aluOp    = ALU_ADD;  // No-op defaults
        ctrl.aluSrc   = 1'b0;
        ctrl.shamt    = 5'd0;
        ctrl.regDst   = REG_DST_RT;
        ctrl.wbSel    = WB_ALU;
        ctrl.regWrite = 1'b0;
        isBranch      = 1'b0;
        jumpSel       = PC_INC;

        case (instr.rType.op)
            OP_SPECIAL: begin
                ctrl.regDst   = REG_DST_RD;
                ctrl.shamt    = instr.rType.shamt; // Only fixed shifts look at it
                ctrl.regWrite = 1'b1;
                case (instr.rType.funct)
                    FN_ADDU: ctrl.aluOp = ALU_ADD;
                    FN_SUBU: ctrl.aluOp = ALU_SUB;
                    FN_AND:  ctrl.aluOp = ALU_AND;
                    FN_OR:   ctrl.aluOp = ALU_OR;
                    FN_XOR:  ctrl.aluOp = ALU_XOR;
                    FN_SLT:  ctrl.aluOp = ALU_SLT;
                    FN_SLTU: ctrl.aluOp = ALU_SLTU;
                    FN_SLL:  ctrl.aluOp = ALU_SLL;
                    FN_SRL:  ctrl.aluOp = ALU_SRL;
                    FN_SRA:  ctrl.aluOp = ALU_SRA;
                    FN_SLLV: ctrl.aluOp = ALU_SLLV;
                    FN_SRLV: ctrl.aluOp = ALU_SRLV;
                    FN_SRAV: ctrl.aluOp = ALU_SRAV;
                    FN_JR: begin
                        jumpSel       = PC_REG;
                        ctrl.regWrite = 1'b0;
                    end
                    FN_JALR: begin
                        jumpSel    = PC_REG;
                        ctrl.wbSel = WB_LINK; // Link goes to rd
                    end
                    default: ctrl.regWrite = 1'b0; // Unknown funct acts as no-op
                endcase
            end
            OP_REGIMM: begin
                case (regimm_e'(instr.iType.rt))
                    RI_BLTZ: begin
                        ctrl.aluOp = ALU_LES;
                        isBranch   = 1'b1;
                    end
                    RI_BGEZ: begin
                        ctrl.aluOp = ALU_GEQ;
                        isBranch   = 1'b1;
                    end
                    default: ;
                endcase
            end
            OP_J: jumpSel = PC_JUMP;
            OP_JAL: begin
                jumpSel       = PC_JUMP;
                ctrl.regDst   = REG_DST_LINK;
                ctrl.wbSel    = WB_LINK;
                ctrl.regWrite = 1'b1;
            end
            OP_BEQ: begin
                ctrl.aluOp = ALU_EQ;
                isBranch   = 1'b1;
            end
            OP_BNE: begin
                ctrl.aluOp = ALU_NEQ;
                isBranch   = 1'b1;
            end
            OP_BLEZ: begin
                ctrl.aluOp = ALU_LEQ;
                isBranch   = 1'b1;
            end
            OP_BGTZ: begin
                ctrl.aluOp = ALU_GRT;
                isBranch   = 1'b1;
            end
            OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
                case (instr.iType.op)
                    OP_SLTI:  ctrl.aluOp = ALU_SLT;
                    OP_SLTIU: ctrl.aluOp = ALU_SLTU;
                    OP_ANDI:  ctrl.aluOp = ALU_AND;
                    OP_ORI:   ctrl.aluOp = ALU_OR;
                    OP_XORI:  ctrl.aluOp = ALU_XOR;
                    OP_LUI: begin
                        ctrl.aluOp = ALU_SLL;  // Immediate moved to upper half
                        ctrl.shamt = 5'd16;
                    end
                    default:  ctrl.aluOp = ALU_ADD;
                endcase
            end
            default: ;
        endcase
    end

    // Branch outcome folded in after the ALU compare settles
    always_comb begin
        if (isBranch && branchCond) begin
            ctrl.pcSel = PC_BRANCH;
        end else begin
            ctrl.pcSel = jumpSel;
        end
    end

endmodule

//--- source/ctrlIf.sv
`timescale 1ns/10ps

interface ctrlIf;
    import cpuPkg::*;

    aluOp_e     aluOp;
    logic       aluSrc;   // High selects the immediate for operand B
    logic [4:0] shamt;
    regDst_e    regDst;
    pcSel_e     pcSel;
    wbSel_e     wbSel;
    logic       regWrite;

    modport decoder (
        output aluOp, aluSrc, shamt, regDst, pcSel, wbSel, regWrite
    );

    modport execute (
        input aluOp, aluSrc, shamt
    );

    modport result (
        input regDst, pcSel, wbSel, regWrite
    );

endinterface

//--- source/cpuPkg.sv
package cpuPkg;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'd0,
        OP_REGIMM  = 6'd1,
        OP_J       = 6'd2,
        OP_JAL     = 6'd3,
        OP_BEQ     = 6'd4,
        OP_BNE     = 6'd5,
        OP_BLEZ    = 6'd6,
        OP_BGTZ    = 6'd7,
        OP_ADDIU   = 6'd9,
        OP_SLTI    = 6'd10,
        OP_SLTIU   = 6'd11,
        OP_ANDI    = 6'd12,
        OP_ORI     = 6'd13,
        OP_XORI    = 6'd14,
        OP_LUI     = 6'd15
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SLL  = 6'd0,
        FN_SRL  = 6'd2,
        FN_SRA  = 6'd3,
        FN_SLLV = 6'd4,
        FN_SRLV = 6'd6,
        FN_SRAV = 6'd7,
        FN_JR   = 6'd8,
        FN_JALR = 6'd9,
        FN_ADDU = 6'd33,
        FN_SUBU = 6'd35,
        FN_AND  = 6'd36,
        FN_OR   = 6'd37,
        FN_XOR  = 6'd38,
        FN_SLT  = 6'd42,
        FN_SLTU = 6'd43
    } funct_e;

    typedef enum logic [4:0] {
        RI_BLTZ = 5'd0,
        RI_BGEZ = 5'd1
    } regimm_e;

    // Gaps in the numbering belong to mul, div and pass ops not built here
    typedef enum logic [4:0] {
        ALU_ADD  = 5'd0,
        ALU_SUB  = 5'd1,
        ALU_AND  = 5'd4,
        ALU_OR   = 5'd5,
        ALU_XOR  = 5'd6,
        ALU_SLL  = 5'd7,
        ALU_SLLV = 5'd8,
        ALU_SRL  = 5'd9,
        ALU_SRLV = 5'd10,
        ALU_SRA  = 5'd11,
        ALU_SRAV = 5'd12,
        ALU_EQ   = 5'd13,
        ALU_LES  = 5'd14,
        ALU_LEQ  = 5'd15,
        ALU_GRT  = 5'd16,
        ALU_GEQ  = 5'd17,
        ALU_NEQ  = 5'd18,
        ALU_SLT  = 5'd20,
        ALU_SLTU = 5'd21
    } aluOp_e;

    typedef enum logic [1:0] {
        REG_DST_RT   = 2'd0,
        REG_DST_RD   = 2'd1,
        REG_DST_LINK = 2'd2 // Register 31
    } regDst_e;

    typedef enum logic [1:0] {
        PC_INC    = 2'd0,
        PC_BRANCH = 2'd1,
        PC_JUMP   = 2'd2,
        PC_REG    = 2'd3
    } pcSel_e;

    typedef enum logic {
        WB_ALU  = 1'b0,
        WB_LINK = 1'b1 // pc + 8
    } wbSel_e;

    typedef struct packed {
        opcode_e    op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        funct_e     funct;
    } rType_t;

    typedef struct packed {
        opcode_e     op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } iType_t;

    typedef struct packed {
        opcode_e     op;
        logic [25:0] target;
    } jType_t;

    typedef union packed {
        rType_t rType;
        iType_t iType;
        jType_t jType;
    } instrWord_t;

endpackage
